// ==== dap_config.svh ====
`ifndef DAP_CONFIG_SVH
`define DAP_CONFIG_SVH

// Clock and buffer sizing
`define DAP_CLOCK_FREQ_M 60
`define DAP_FIFO_DEPTH   256
`define DAP_DR_TIMEOUT   15

// ----------------------------------------
// Register map
// ----------------------------------------
`define DAP_CR_ADDR     12'h000
`define DAP_TIME_ADDR   12'h004
`define DAP_SR_ADDR     12'h008
`define DAP_DR_ADDR     12'h00C
`define DAP_CURCMD_ADDR 12'h010

// ----------------------------------------
// CMSIS-DAP command bytes
// ----------------------------------------
`define DAP_CMD_ABORT   8'h07
`define DAP_CMD_DELAY   8'h09
`define DAP_CMD_QUEUE   8'h7E
`define DAP_CMD_EXEC    8'h7F
`define DAP_STATUS_OK   8'h00

`endif

// ==== dap_bus_pkg.sv ====
package dap_bus_pkg;

    // Register offset within the slave window
    typedef logic [11:0] haddr_t;

    // AHB data word
    typedef logic [31:0] hdata_t;

    // One bit per byte lane
    typedef logic [3:0] strobe_t;

endpackage

// ==== dap_cmd_pkg.sv ====
package dap_cmd_pkg;

    // One byte of the command or response stream
    typedef logic [7:0] cmd_byte_t;

    // Response packet length, also the FIFO fill level
    typedef logic [11:0] pack_len_t;

    // What the sequencer does with a command byte
    typedef enum logic [1:0] {
        CLASS_ABORT,
        CLASS_QUEUE,
        CLASS_DELAY,
        CLASS_HELPER
    } cmd_class_t;

    // Sequencer FSM
    typedef enum logic [1:0] {
        SEQ_CMD,
        SEQ_NUM,
        SEQ_BUSY,
        SEQ_DRAIN
    } seq_state_t;

endpackage

// ==== dap_ahb_slave.sv ====
`timescale 1ns/1ns

module dap_ahb_slave (
    input  logic                  hclk,
    input  logic                  hresetn,
    input  logic                  hsel,
    input  dap_bus_pkg::haddr_t   haddr,
    input  logic [1:0]            htrans,
    input  logic [2:0]            hsize,
    input  logic                  hwrite,
    input  logic                  hready,
    output dap_bus_pkg::haddr_t   addr,
    output logic                  read_en,
    output logic                  write_en,
    output dap_bus_pkg::strobe_t  strobe
);
    import dap_bus_pkg::*;

    logic    trans_req;
    strobe_t strobe_nxt;

    // NONSEQ or SEQ with the previous transfer finished
    assign trans_req = hsel && htrans[1] && hready;

    // Lane strobes from transfer size and low address bits
    always_comb begin
        case (hsize)
            3'b000:  strobe_nxt = strobe_t'(4'b0001 << haddr[1:0]);
            3'b001:  strobe_nxt = haddr[1] ? 4'b1100 : 4'b0011;
            default: strobe_nxt = 4'b1111;
        endcase
    end

    // ----------------------------------------
    // Address phase registration
    // ----------------------------------------
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            addr     <= '0;
            read_en  <= 1'b0;
            write_en <= 1'b0;
            strobe   <= '0;
        end else begin
            if (trans_req) begin
                addr   <= haddr;
                strobe <= strobe_nxt;
            end
            // Enables held through wait states, replaced when hready ends the data phase
            if (hready) begin
                read_en  <= trans_req && !hwrite;
                write_en <= trans_req && hwrite;
            end
        end
    end

endmodule

// ==== dap_regs.sv ====
`timescale 1ns/1ns
`include "dap_config.svh"

module dap_regs (
    input  logic                   hclk,
    input  logic                   hresetn,
    input  dap_bus_pkg::haddr_t    addr,
    input  logic                   read_en,
    input  logic                   write_en,
    input  dap_bus_pkg::strobe_t   strobe,
    input  dap_bus_pkg::hdata_t    hwdata,
    input  logic                   dap_in_tvalid,
    input  dap_cmd_pkg::cmd_byte_t dap_in_tdata,
    input  logic                   helper_busy,
    input  dap_cmd_pkg::cmd_byte_t processing_cmd,
    output dap_bus_pkg::hdata_t    hrdata,
    output logic                   hreadyout,
    output logic                   dap_en,
    output logic                   int_en,
    output logic                   helper_release,
    output logic                   dr_write,
    output logic                   dr_read,
    output logic                   us_tick
);
    import dap_bus_pkg::*;

    localparam int DIV_W = $clog2(`DAP_CLOCK_FREQ_M);
    localparam int TO_W  = $clog2(`DAP_DR_TIMEOUT + 1);

    hdata_t            cr_q;
    hdata_t            clk_count;
    logic [DIV_W-1:0]  us_div;
    logic [TO_W-1:0]   dr_wait;
    logic              time_write;

    // Word match, byte offset ignored
    function automatic logic hit(input haddr_t a, input haddr_t base);
        return a[11:2] == base[11:2];
    endfunction

    assign dap_en         = cr_q[0];
    assign int_en         = cr_q[31];
    assign time_write     = write_en && hit(addr, `DAP_TIME_ADDR);
    assign dr_write       = write_en && hit(addr, `DAP_DR_ADDR) && strobe[0];
    assign dr_read        = read_en && hit(addr, `DAP_DR_ADDR);
    assign helper_release = write_en && hit(addr, `DAP_SR_ADDR) && strobe[3] && hwdata[31];
    assign us_tick        = us_div == DIV_W'(`DAP_CLOCK_FREQ_M - 1);

    // CR with byte lane writes
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            cr_q <= '0;
        end else if (write_en && hit(addr, `DAP_CR_ADDR)) begin
            for (int i = 0; i < 4; i++) begin
                if (strobe[i]) begin
                    cr_q[8*i +: 8] <= hwdata[8*i +: 8];
                end
            end
        end
    end

    // ----------------------------------------
    // Time stamp and microsecond divider
    // ----------------------------------------
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            clk_count <= '0;
            us_div    <= '0;
        end else if (time_write) begin
            clk_count <= '0;
            us_div    <= '0;
        end else begin
            clk_count <= clk_count + 32'd1;
            us_div    <= us_tick ? '0 : us_div + 1'b1;
        end
    end

    // DR read waits for input data or gives up after the timeout
    assign hreadyout = !dr_read || dap_in_tvalid || (dr_wait == TO_W'(`DAP_DR_TIMEOUT));

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            dr_wait <= '0;
        end else if (dr_read && !hreadyout) begin
            dr_wait <= dr_wait + 1'b1;
        end else begin
            dr_wait <= '0;
        end
    end

    // Read data mux
    always_comb begin
        hrdata = '0;
        if (read_en) begin
            case (1'b1)
                hit(addr, `DAP_CR_ADDR):     hrdata = cr_q;
                hit(addr, `DAP_TIME_ADDR):   hrdata = clk_count;
                hit(addr, `DAP_SR_ADDR):     hrdata = {helper_busy, 31'd0};
                hit(addr, `DAP_DR_ADDR):     hrdata = {4{dap_in_tdata}};
                hit(addr, `DAP_CURCMD_ADDR): hrdata = {24'd0, processing_cmd};
                default:                     hrdata = '0;
            endcase
        end
    end

    // A stalled DR read always completes
    a_dr_stall_bound: assert property (@(posedge hclk) disable iff (!hresetn)
        $fell(hreadyout) |-> ##[1:`DAP_DR_TIMEOUT + 1] hreadyout);

endmodule

// ==== dap_sequencer.sv ====
`timescale 1ns/1ns
`include "dap_config.svh"

module dap_sequencer (
    input  logic                   hclk,
    input  logic                   hresetn,
    input  logic                   dap_en,
    input  logic                   int_en,
    input  logic                   dap_in_tvalid,
    input  dap_cmd_pkg::cmd_byte_t dap_in_tdata,
    input  logic                   helper_release,
    input  logic                   dr_write,
    input  dap_cmd_pkg::cmd_byte_t hwdata_lo,
    input  logic                   delay_done,
    input  logic                   delay_tready,
    input  logic                   delay_push,
    input  dap_cmd_pkg::cmd_byte_t delay_byte,
    input  logic                   fifo_empty,
    input  dap_cmd_pkg::pack_len_t fifo_count,
    output logic                   seq_tready,
    output logic                   delay_start,
    output logic                   helper_busy,
    output dap_cmd_pkg::cmd_byte_t processing_cmd,
    output logic                   intr,
    output logic                   fifo_push,
    output dap_cmd_pkg::cmd_byte_t fifo_wdata,
    output logic                   fifo_pop_en,
    output dap_cmd_pkg::pack_len_t dap_out_tlen
);
    import dap_cmd_pkg::*;

    seq_state_t state;
    cmd_class_t in_class;
    cmd_class_t cur_class;
    cmd_byte_t  num_cmd;
    logic       in_fire;
    logic       cmd_done;

    function automatic cmd_class_t decode(input cmd_byte_t cmd);
        case (cmd)
            `DAP_CMD_ABORT:                return CLASS_ABORT;
            `DAP_CMD_QUEUE, `DAP_CMD_EXEC: return CLASS_QUEUE;
            `DAP_CMD_DELAY:                return CLASS_DELAY;
            default:                       return CLASS_HELPER;
        endcase
    endfunction

    assign in_class   = decode(dap_in_tdata);
    assign seq_tready = (state == SEQ_CMD) || (state == SEQ_NUM);
    assign in_fire    = dap_en && seq_tready && dap_in_tvalid;
    assign intr       = int_en && helper_busy;

    // Firmware finishes helper commands, the worker finishes delays
    assign cmd_done = (cur_class == CLASS_HELPER) ? helper_release : delay_done;

    // ----------------------------------------
    // Command FSM
    // ----------------------------------------
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            state          <= SEQ_CMD;
            cur_class      <= CLASS_HELPER;
            num_cmd        <= '0;
            processing_cmd <= '0;
            helper_busy    <= 1'b0;
            delay_start    <= 1'b0;
            fifo_pop_en    <= 1'b0;
            dap_out_tlen   <= '0;
        end else if (!dap_en) begin
            state       <= SEQ_CMD;
            num_cmd     <= '0;
            helper_busy <= 1'b0;
            delay_start <= 1'b0;
            fifo_pop_en <= 1'b0;
        end else begin
            delay_start <= 1'b0;
            case (state)
                SEQ_CMD: begin
                    if (in_fire) begin
                        processing_cmd <= dap_in_tdata;
                        cur_class      <= in_class;
                        if (in_class == CLASS_QUEUE) begin
                            state <= SEQ_NUM;
                        end else if (in_class != CLASS_ABORT) begin
                            state       <= SEQ_BUSY;
                            delay_start <= in_class == CLASS_DELAY;
                            helper_busy <= in_class == CLASS_HELPER;
                        end
                    end
                end
                SEQ_NUM: begin
                    if (in_fire) begin
                        num_cmd <= dap_in_tdata;
                        state   <= SEQ_CMD;
                    end
                end
                SEQ_BUSY: begin
                    if (cmd_done) begin
                        helper_busy <= 1'b0;
                        // More queued commands to come
                        if (num_cmd > 8'd1) begin
                            num_cmd <= num_cmd - 8'd1;
                            state   <= SEQ_CMD;
                        end else begin
                            num_cmd <= '0;
                            state   <= SEQ_DRAIN;
                        end
                    end
                end
                SEQ_DRAIN: begin
                    if (!fifo_pop_en) begin
                        dap_out_tlen <= fifo_count;
                        fifo_pop_en  <= 1'b1;
                    end else if (fifo_empty) begin
                        fifo_pop_en <= 1'b0;
                        state       <= SEQ_CMD;
                    end
                end
                default: state <= SEQ_CMD;
            endcase
        end
    end

    // FIFO write routing, firmware has priority
    always_comb begin
        if (dr_write) begin
            fifo_push  = 1'b1;
            fifo_wdata = hwdata_lo;
        end else if (seq_tready) begin
            fifo_push  = in_fire && (state == SEQ_NUM || in_class != CLASS_ABORT);
            fifo_wdata = dap_in_tdata;
        end else begin
            fifo_push  = delay_push;
            fifo_wdata = delay_byte;
        end
    end

    // Worker only takes input or finishes while a command is in progress
    a_worker_in_busy: assert property (@(posedge hclk) disable iff (!hresetn)
        (delay_done || delay_tready) |-> state == SEQ_BUSY);

endmodule

// ==== dap_delay.sv ====
`timescale 1ns/1ns
`include "dap_config.svh"

module dap_delay (
    input  logic                   hclk,
    input  logic                   hresetn,
    input  logic                   dap_en,
    input  logic                   us_tick,
    input  logic                   delay_start,
    input  logic                   dap_in_tvalid,
    input  dap_cmd_pkg::cmd_byte_t dap_in_tdata,
    output logic                   delay_tready,
    output logic                   delay_done,
    output logic                   delay_push,
    output dap_cmd_pkg::cmd_byte_t delay_byte
);
    typedef enum logic [1:0] {
        DLY_IDLE,
        DLY_LO,
        DLY_HI,
        DLY_WAIT
    } dly_state_t;

    dly_state_t  state;
    logic [15:0] us_left;

    assign delay_tready = (state == DLY_LO) || (state == DLY_HI);

    // Final tick with nothing left; status byte goes out with it
    assign delay_done = (state == DLY_WAIT) && us_tick && (us_left == 16'd0);
    assign delay_push = delay_done;
    assign delay_byte = `DAP_STATUS_OK;

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            state   <= DLY_IDLE;
            us_left <= '0;
        end else if (!dap_en) begin
            state <= DLY_IDLE;
        end else begin
            case (state)
                DLY_IDLE: begin
                    if (delay_start) begin
                        state <= DLY_LO;
                    end
                end
                // Little-endian microsecond count
                DLY_LO: begin
                    if (dap_in_tvalid) begin
                        us_left[7:0] <= dap_in_tdata;
                        state        <= DLY_HI;
                    end
                end
                DLY_HI: begin
                    if (dap_in_tvalid) begin
                        us_left[15:8] <= dap_in_tdata;
                        state         <= DLY_WAIT;
                    end
                end
                DLY_WAIT: begin
                    if (us_tick) begin
                        if (us_left == 16'd0) begin
                            state <= DLY_IDLE;
                        end else begin
                            us_left <= us_left - 16'd1;
                        end
                    end
                end
                default: state <= DLY_IDLE;
            endcase
        end
    end

endmodule

// ==== dap_out_fifo.sv ====
`timescale 1ns/1ns
`include "dap_config.svh"

module dap_out_fifo (
    input  logic                   hclk,
    input  logic                   hresetn,
    input  logic                   fifo_push,
    input  dap_cmd_pkg::cmd_byte_t fifo_wdata,
    input  logic                   fifo_pop_en,
    input  logic                   dap_out_tready,
    output logic                   dap_out_tvalid,
    output dap_cmd_pkg::cmd_byte_t dap_out_tdata,
    output logic                   fifo_empty,
    output dap_cmd_pkg::pack_len_t fifo_count
);
    import dap_cmd_pkg::*;

    localparam int PTR_W = $clog2(`DAP_FIFO_DEPTH);

    cmd_byte_t        mem [`DAP_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             full;
    logic             wr_ok;
    logic             rd_ok;

    assign fifo_empty     = fifo_count == '0;
    assign full           = fifo_count == pack_len_t'(`DAP_FIFO_DEPTH);
    assign wr_ok          = fifo_push && !full;
    assign dap_out_tvalid = fifo_pop_en && !fifo_empty;
    assign rd_ok          = dap_out_tvalid && dap_out_tready;
    assign dap_out_tdata  = mem[rd_ptr];

    always_ff @(posedge hclk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= fifo_wdata;
        end
    end

    // Pointers wrap on the power-of-two depth
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            wr_ptr     <= wr_ptr + PTR_W'(wr_ok);
            rd_ptr     <= rd_ptr + PTR_W'(rd_ok);
            fifo_count <= fifo_count + pack_len_t'(wr_ok) - pack_len_t'(rd_ok);
        end
    end

    a_no_overflow: assert property (@(posedge hclk) disable iff (!hresetn)
        fifo_push |-> !full);

endmodule

// ==== dap_controller.sv ====
`timescale 1ns/1ns

module dap_controller (
    input  logic                   hclk,
    input  logic                   hresetn,
    input  logic                   hsel,
    input  dap_bus_pkg::haddr_t    haddr,
    input  logic [1:0]             htrans,
    input  logic [2:0]             hsize,
    input  logic                   hwrite,
    input  logic                   hready,
    input  dap_bus_pkg::hdata_t    hwdata,
    output logic                   hreadyout,
    output logic                   hresp,
    output dap_bus_pkg::hdata_t    hrdata,
    output logic                   intr,
    input  logic                   dap_in_tvalid,
    output logic                   dap_in_tready,
    input  dap_cmd_pkg::cmd_byte_t dap_in_tdata,
    output logic                   dap_out_tvalid,
    output dap_cmd_pkg::cmd_byte_t dap_out_tdata,
    input  logic                   dap_out_tready,
    output dap_cmd_pkg::pack_len_t dap_out_tlen
);
    import dap_bus_pkg::*;
    import dap_cmd_pkg::*;

    // Bus front end to registers
    haddr_t    addr;
    logic      read_en;
    logic      write_en;
    strobe_t   strobe;

    // Register block outputs
    logic      dap_en;
    logic      int_en;
    logic      helper_release;
    logic      dr_write;
    logic      dr_read;
    logic      us_tick;

    // Sequencer, worker and FIFO
    logic      helper_busy;
    cmd_byte_t processing_cmd;
    logic      seq_tready;
    logic      delay_start;
    logic      delay_done;
    logic      delay_tready;
    logic      delay_push;
    cmd_byte_t delay_byte;
    logic      fifo_push;
    cmd_byte_t fifo_wdata;
    logic      fifo_pop_en;
    logic      fifo_empty;
    pack_len_t fifo_count;

    // Any of the three consumers takes the input byte
    assign dap_in_tready = dap_en && (seq_tready || delay_tready || dr_read);
    assign hresp         = 1'b0;

    dap_ahb_slave dap_ahb_slave_inst (.*);

    dap_regs dap_regs_inst (.*);

    dap_sequencer dap_sequencer_inst (
        .hwdata_lo (hwdata[7:0]),
        .*
    );

    dap_delay dap_delay_inst (.*);

    dap_out_fifo dap_out_fifo_inst (.*);

endmodule

// ==== tb_dap_tests.svh ====
`ifndef TB_DAP_TESTS_SVH
`define TB_DAP_TESTS_SVH

localparam int N_CR_WRITES   = 8;
localparam int N_DELAY_RUNS  = 3;
localparam int N_HELPER_RUNS = 2;
localparam int N_QUEUE_RUNS  = 2;
localparam int MAX_DELAY_US  = 20;
localparam int MAX_QUEUED    = 3;
localparam int MAX_QUEUE_US  = 3;

// Worst case delay time doubled for back-pressure and padded for bus traffic
localparam int WATCHDOG_CYCLES = 2 * `DAP_CLOCK_FREQ_M *
    (N_DELAY_RUNS * (MAX_DELAY_US + 1) + (N_QUEUE_RUNS * MAX_QUEUED + 1) * (MAX_QUEUE_US + 1))
    + 5000;

// Expected response packet
cmd_byte_t exp_bytes[$];
time       last_in_time;

task automatic check_packet();
    while (got_bytes.size() < exp_bytes.size()) begin
        @(posedge hclk);
    end
    repeat (8) @(posedge hclk);
    assert (got_bytes.size() == exp_bytes.size())
        else value_error("packet byte count", got_bytes.size(), exp_bytes.size());
    for (int i = 0; i < exp_bytes.size(); i++) begin
        assert (got_bytes[i] == exp_bytes[i])
            else value_error("dap_out_tdata", got_bytes[i], exp_bytes[i]);
        assert (got_lens[i] == pack_len_t'(exp_bytes.size()))
            else value_error("dap_out_tlen", got_lens[i], exp_bytes.size());
    end
    got_bytes.delete();
    got_lens.delete();
    exp_bytes.delete();
endtask

// Delay command with a little-endian microsecond count
task automatic send_delay(input logic [15:0] us);
    exp_bytes.push_back(`DAP_CMD_DELAY);
    exp_bytes.push_back(`DAP_STATUS_OK);
    send_byte(`DAP_CMD_DELAY);
    send_byte(us[7:0]);
    send_byte(us[15:8]);
    last_in_time = $time;
endtask

// ----------------------------------------
// Test sequences
// ----------------------------------------
task automatic cr_lane_test();
    hdata_t     model;
    hdata_t     data;
    hdata_t     rd;
    logic [2:0] size;
    logic [1:0] off;
    int         first_lane;
    int         last_lane;
    model = '0;
    repeat (N_CR_WRITES) begin
        size = 3'($urandom % 3);
        data = $urandom;
        case (size)
            3'd0:    off = 2'($urandom % 4);
            3'd1:    off = 2'(($urandom % 2) * 2);
            default: off = 2'd0;
        endcase
        // Bytes from the address up to the transfer size
        first_lane = int'(off);
        last_lane  = first_lane + (1 << size) - 1;
        for (int i = 0; i < 4; i++) begin
            if (i >= first_lane && i <= last_lane) begin
                model[8*i +: 8] = data[8*i +: 8];
            end
        end
        ahb_write(haddr_t'(`DAP_CR_ADDR) + haddr_t'(off), size, data);
        ahb_read(`DAP_CR_ADDR, rd);
        assert (rd == model) else value_error("hrdata (CR)", rd, model);
    end
endtask

task automatic delay_test();
    int unsigned us;
    longint      waited;
    us = $urandom % (MAX_DELAY_US + 1);
    send_delay(16'(us));
    check_packet();
    waited = (first_out_time - last_in_time) / CLK_PERIOD;
    assert (waited >= us * `DAP_CLOCK_FREQ_M)
        else fail_run($sformatf(
            "Error at %0t ns: delay latency %0d cycles, expected at least %0d",
            $time, waited, us * `DAP_CLOCK_FREQ_M));
endtask

task automatic helper_test();
    cmd_byte_t cmd;
    cmd_byte_t b;
    hdata_t    rd;
    hdata_t    wd;
    time       t_start;
    int        stalls;
    do begin
        cmd = 8'($urandom);
    end while (cmd inside {`DAP_CMD_ABORT, `DAP_CMD_DELAY, `DAP_CMD_QUEUE, `DAP_CMD_EXEC});
    exp_bytes.push_back(cmd);
    send_byte(cmd);
    while (!intr) begin
        @(posedge hclk);
    end
    ahb_read(`DAP_CURCMD_ADDR, rd);
    assert (rd == {24'd0, cmd}) else value_error("hrdata (CURCMD)", rd, {24'd0, cmd});
    // DR read with no input byte gives up after the timeout
    t_start = $time;
    ahb_read(`DAP_DR_ADDR, rd);
    // Address phase and the final data cycle are not stalls
    stalls = int'(($time - t_start) / CLK_PERIOD) - 2;
    assert (stalls == `DAP_DR_TIMEOUT)
        else value_error("DR stall cycles", stalls, `DAP_DR_TIMEOUT);
    // Payload bytes come back through DR in order
    repeat (1 + $urandom % 4) begin
        b = 8'($urandom);
        dap_in_tvalid <= 1'b1;
        dap_in_tdata  <= b;
        ahb_read(`DAP_DR_ADDR, rd);
        dap_in_tvalid <= 1'b0;
        assert (rd == {4{b}}) else value_error("hrdata (DR)", rd, {4{b}});
    end
    repeat (1 + $urandom % 4) begin
        wd = $urandom;
        exp_bytes.push_back(wd[7:0]);
        ahb_write(`DAP_DR_ADDR, 3'b000, wd);
    end
    ahb_write(`DAP_SR_ADDR, 3'b010, 32'h8000_0000);
    @(posedge hclk);
    assert (!intr) else value_error("intr", intr, 1'b0);
    check_packet();
endtask

task automatic queue_test();
    int unsigned n;
    n = 1 + $urandom % MAX_QUEUED;
    exp_bytes.push_back(`DAP_CMD_QUEUE);
    exp_bytes.push_back(8'(n));
    send_byte(`DAP_CMD_QUEUE);
    send_byte(8'(n));
    repeat (n) begin
        send_delay(16'($urandom % (MAX_QUEUE_US + 1)));
    end
    check_packet();
endtask

task automatic abort_test();
    send_byte(`DAP_CMD_ABORT);
    repeat (10) @(posedge hclk);
    assert (got_bytes.size() == 0)
        else value_error("output byte count after abort", got_bytes.size(), 0);
    send_delay(16'($urandom % (MAX_QUEUE_US + 1)));
    check_packet();
endtask

// Disabled input stream then time stamp clear
task automatic disable_test();
    hdata_t t_before;
    hdata_t t_after;
    ahb_write(`DAP_CR_ADDR, 3'b010, 32'h0);
    dap_in_tvalid <= 1'b1;
    dap_in_tdata  <= 8'($urandom);
    repeat (20) begin
        @(posedge hclk);
        assert (!dap_in_tready) else value_error("dap_in_tready", dap_in_tready, 1'b0);
    end
    dap_in_tvalid <= 1'b0;
    ahb_read(`DAP_TIME_ADDR, t_before);
    ahb_write(`DAP_TIME_ADDR, 3'b010, $urandom);
    ahb_read(`DAP_TIME_ADDR, t_after);
    assert (t_after < t_before)
        else fail_run($sformatf("Error at %0t ns: hrdata (TIME) is %h, not below earlier %h",
                                $time, t_after, t_before));
endtask

task automatic run_all_tests();
    cr_lane_test();
    // Enable plus interrupt enable
    ahb_write(`DAP_CR_ADDR, 3'b010, 32'h8000_0001);
    repeat (N_DELAY_RUNS) delay_test();
    repeat (N_HELPER_RUNS) helper_test();
    repeat (N_QUEUE_RUNS) queue_test();
    abort_test();
    disable_test();
endtask

`endif

// ==== tb_dap_controller.sv ====
`timescale 1ns/1ns
`include "dap_config.svh"

module tb_dap_controller;
    import dap_bus_pkg::*;
    import dap_cmd_pkg::*;

    localparam int          CLK_PERIOD = 40;
    localparam int unsigned SEED       = 32'h0db0f36b;

    logic      hclk;
    logic      hresetn;
    logic      hsel;
    haddr_t    haddr;
    logic [1:0] htrans;
    logic [2:0] hsize;
    logic      hwrite;
    logic      hready;
    hdata_t    hwdata;
    logic      hreadyout;
    logic      hresp;
    hdata_t    hrdata;
    logic      intr;
    logic      dap_in_tvalid;
    logic      dap_in_tready;
    cmd_byte_t dap_in_tdata;
    logic      dap_out_tvalid;
    cmd_byte_t dap_out_tdata;
    logic      dap_out_tready;
    pack_len_t dap_out_tlen;

    // Bytes and lengths seen on the output stream
    cmd_byte_t got_bytes[$];
    pack_len_t got_lens[$];
    time       first_out_time;

    // Single slave on the bus
    assign hready = hreadyout;

    dap_controller dap_controller_inst (.*);

    initial begin
        hclk = 1'b0;
        forever #(CLK_PERIOD / 2) hclk = ~hclk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        fail_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    endtask

    // ----------------------------------------
    // AHB master tasks
    // ----------------------------------------
    task automatic ahb_write(input haddr_t a, input logic [2:0] size, input hdata_t data);
        hsel   <= 1'b1;
        haddr  <= a;
        htrans <= 2'b10;
        hsize  <= size;
        hwrite <= 1'b1;
        @(posedge hclk);
        hsel   <= 1'b0;
        htrans <= 2'b00;
        hwdata <= data;
        do @(posedge hclk); while (!hreadyout);
    endtask

    task automatic ahb_read(input haddr_t a, output hdata_t data);
        hsel   <= 1'b1;
        haddr  <= a;
        htrans <= 2'b10;
        hsize  <= 3'b010;
        hwrite <= 1'b0;
        @(posedge hclk);
        hsel   <= 1'b0;
        htrans <= 2'b00;
        // Data phase ends on the first edge with hreadyout high
        do @(posedge hclk); while (!hreadyout);
        data = hrdata;
    endtask

    // Input stream byte, with a short random idle gap first
    task automatic send_byte(input cmd_byte_t b);
        repeat ($urandom % 3) @(posedge hclk);
        dap_in_tvalid <= 1'b1;
        dap_in_tdata  <= b;
        do @(posedge hclk); while (!dap_in_tready);
        dap_in_tvalid <= 1'b0;
    endtask

    // Random back-pressure on the output stream
    task automatic throttle_out();
        forever begin
            @(posedge hclk);
            dap_out_tready <= ($urandom % 4) != 0;
        end
    endtask

    // Output monitor
    always @(posedge hclk) begin
        if (hresetn) begin
            assert (hresp == 1'b0) else value_error("hresp", hresp, 1'b0);
            if (dap_out_tvalid && dap_out_tready) begin
                if (got_bytes.size() == 0) begin
                    first_out_time = $time;
                end
                got_bytes.push_back(dap_out_tdata);
                got_lens.push_back(dap_out_tlen);
            end
        end
    end

    `include "tb_dap_tests.svh"

    // Watchdog sized from the delay totals
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge hclk);
        fail_run($sformatf("Timeout: run exceeded %0d clock cycles", WATCHDOG_CYCLES));
    end

    initial begin
        void'($urandom(SEED));
        hresetn        = 1'b0;
        hsel           = 1'b0;
        haddr          = '0;
        htrans         = 2'b00;
        hsize          = 3'b000;
        hwrite         = 1'b0;
        hwdata         = '0;
        dap_in_tvalid  = 1'b0;
        dap_in_tdata   = '0;
        dap_out_tready = 1'b0;
        first_out_time = 0;
        fork
            throttle_out();
        join_none
        repeat (5) @(posedge hclk);
        hresetn <= 1'b1;
        @(posedge hclk);
        run_all_tests();
        repeat (10) @(posedge hclk);
        if (got_bytes.size() == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            fail_run("Output bytes arrived after the last expected packet");
        end
    end

endmodule

// ==== dap_controller.f ====
+incdir+.
dap_bus_pkg.sv
dap_cmd_pkg.sv
dap_ahb_slave.sv
dap_regs.sv
dap_sequencer.sv
dap_delay.sv
dap_out_fifo.sv
dap_controller.sv
tb_dap_controller.sv

// ==== Bender.yml ====
package:
  name: dap_controller

sources:
  - include_dirs:
      - .
    files:
      - dap_bus_pkg.sv
      - dap_cmd_pkg.sv
      - dap_ahb_slave.sv
      - dap_regs.sv
      - dap_sequencer.sv
      - dap_delay.sv
      - dap_out_fifo.sv
      - dap_controller.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_dap_controller.sv
